/* design/regfile_exec_pkg.sv */
/*
 * Shared definitions for the register-file execute subsystem
 *   register index, instruction word and immediate typedefs
 *   ALU opcode enum and instruction field positions
 */
package regfile_exec_pkg;

    // index into the 32-entry register file
    typedef logic [4:0]  reg_addr_t;

    typedef logic [31:0] instr_t;

    // immediate as carried in the instruction, sign-extended in the ALU
    typedef logic [12:0] imm_t;

    // codes 8 to 15 are not assigned and decode as no operation
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LI   = 4'd7
    } alu_op_t;

    // instruction field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 23;
    localparam int RS1_HI = 22;
    localparam int RS1_LO = 18;
    localparam int RS2_HI = 17;
    localparam int RS2_LO = 13;
    localparam int IMM_HI = 12;
    localparam int IMM_LO = 0;

    // read port numbers used by decoder and ALU
    localparam int PORT_RS1 = 0;
    localparam int PORT_RS2 = 1;

endpackage

/* design/exec_if.sv */
/*
 * Decoded operation bundle from the decode stage to the ALU stage
 *   all fields are registered in the decoder
 */
interface exec_if
    import regfile_exec_pkg::*;
();

    logic      valid;
    alu_op_t   op;
    reg_addr_t rd;
    // source indices travel along so the ALU can forward
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;

    modport decoder_mp (
        output valid,
        output op,
        output rd,
        output rs1,
        output rs2,
        output imm
    );

    modport alu_mp (
        input  valid,
        input  op,
        input  rd,
        input  rs1,
        input  rs2,
        input  imm
    );

endinterface

/* design/ram32x1d.sv */
/*
 * 32-deep, 1-bit-wide distributed RAM slice
 *   synchronous write, asynchronous read
 */
module ram32x1d
    import regfile_exec_pkg::*;
#(
    parameter logic [31:0] INIT = 32'd0
) (
    input  logic      clk,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  logic      wdin,
    input  reg_addr_t raddr,
    output logic      rdout
);

    // contents start from INIT at configuration, there is no reset
    logic [31:0] mem = INIT;

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdin;
        end
    end

    // the read side is a plain LUT lookup
    assign rdout = mem[raddr];

endmodule

/* design/register_file.sv */
/*
 * Multi-port register file built from ram32x1d slices
 *   one write port shared by all copies, one RAM copy per read port
 *   write-to-read bypass and registered read data per port
 */
module register_file
    import regfile_exec_pkg::*;
#(
    parameter int READ_PORTS = 2,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                 clk,
    input  logic                                 cke,

    // write port, enable already qualified by cke
    input  logic                                 wr_en,
    input  reg_addr_t                            wr_addr,
    input  logic [DATA_WIDTH-1:0]                wr_din,

    // read ports
    input  logic [READ_PORTS-1:0]                rd_en,
    input  reg_addr_t [READ_PORTS-1:0]           rd_addr,
    output logic [READ_PORTS-1:0][DATA_WIDTH-1:0] rd_dout
);

    for (genvar i = 0; i < READ_PORTS; i++) begin : g_port
        logic                  overwrite;
        logic [DATA_WIDTH-1:0] ram_q;

        // a write to the address being read wins over the stale RAM bit
        assign overwrite = wr_en && (wr_addr == rd_addr[i]);

        for (genvar j = 0; j < DATA_WIDTH; j++) begin : g_bit
            ram32x1d #(
                .INIT  (32'd0)
            ) u_ram (
                .clk   (clk),
                .wen   (wr_en),
                .waddr (wr_addr),
                .wdin  (wr_din[j]),
                .raddr (rd_addr[i]),
                .rdout (ram_q[j])
            );
        end

        // read data holds while the port is idle or the pipeline is frozen
        always_ff @(posedge clk) begin
            if (cke && rd_en[i]) begin
                rd_dout[i] <= overwrite ? wr_din : ram_q;
            end
        end
    end

endmodule

/* design/instr_decoder.sv */
/*
 * Decode stage
 *   splits the instruction into fields and drives the register-file reads
 *   registers the decoded operation into exec_if
 */
module instr_decoder
    import regfile_exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cke,
    input  logic              instr_valid,
    input  instr_t            instr,
    output logic [1:0]        rd_en,
    output reg_addr_t [1:0]   rd_addr,
    exec_if.decoder_mp        dec
);

    alu_op_t   op_f;
    reg_addr_t rd_f;
    reg_addr_t rs1_f;
    reg_addr_t rs2_f;
    imm_t      imm_f;
    logic      op_known;

    // the ALU sign-extends the immediate, so the word must be at least as wide
    if (DATA_WIDTH < $bits(imm_t)) begin : g_width_check
        $error("DATA_WIDTH %0d is narrower than the immediate field", DATA_WIDTH);
    end

    assign op_f  = alu_op_t'(instr[OP_HI:OP_LO]);
    assign rd_f  = instr[RD_HI:RD_LO];
    assign rs1_f = instr[RS1_HI:RS1_LO];
    assign rs2_f = instr[RS2_HI:RS2_LO];
    assign imm_f = instr[IMM_HI:IMM_LO];

    always_comb begin
        case (op_f)
            OP_ADD, OP_SUB, OP_AND, OP_OR,
            OP_XOR, OP_SLL, OP_ADDI, OP_LI: op_known = 1'b1;
            default:                        op_known = 1'b0;
        endcase
    end

    // both sources are read for every instruction, the ALU picks what it needs
    assign rd_en             = {2{instr_valid}};
    assign rd_addr[PORT_RS1] = rs1_f;
    assign rd_addr[PORT_RS2] = rs2_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec.valid <= 1'b0;
        end else if (cke) begin
            // unknown opcodes become bubbles here
            dec.valid <= instr_valid && op_known;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            dec.op  <= op_f;
            dec.rd  <= rd_f;
            dec.rs1 <= rs1_f;
            dec.rs2 <= rs2_f;
            dec.imm <= imm_f;
        end
    end

endmodule

/* design/alu_stage.sv */
/*
 * ALU stage
 *   operand forwarding from the result register
 *   arithmetic and logic operations, result register driving write-back
 */
module alu_stage
    import regfile_exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cke,
    exec_if.alu_mp                      dec,
    input  logic [1:0][DATA_WIDTH-1:0]  rd_dout,
    output logic                        wr_en,
    output reg_addr_t                   wr_addr,
    output logic [DATA_WIDTH-1:0]       wr_din
);

    typedef logic [DATA_WIDTH-1:0] word_t;

    word_t src_a;
    word_t src_b;
    word_t imm_ext;
    word_t result;

    // the previous instruction is still in the result register and not yet
    // in the RAM, so its value has to be taken from here
    always_comb begin
        src_a = rd_dout[PORT_RS1];
        src_b = rd_dout[PORT_RS2];
        if (wr_en && (wr_addr == dec.rs1)) begin
            src_a = wr_din;
        end
        if (wr_en && (wr_addr == dec.rs2)) begin
            src_b = wr_din;
        end
    end

    assign imm_ext = word_t'($signed(dec.imm));

    always_comb begin
        case (dec.op)
            OP_ADD:  result = src_a + src_b;
            OP_SUB:  result = src_a - src_b;
            OP_AND:  result = src_a & src_b;
            OP_OR:   result = src_a | src_b;
            OP_XOR:  result = src_a ^ src_b;
            // shift amount is the low five bits of rs2
            OP_SLL:  result = src_a << src_b[4:0];
            OP_ADDI: result = src_a + imm_ext;
            OP_LI:   result = imm_ext;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
        end else if (cke) begin
            wr_en <= dec.valid;
        end
    end

    // destination and data are only meaningful while wr_en is set
    always_ff @(posedge clk) begin
        if (cke) begin
            wr_addr <= dec.rd;
            wr_din  <= result;
        end
    end

endmodule

/* design/exec_top.sv */
/*
 * Execute subsystem top level
 *   decode stage, two-read-port register file and ALU stage
 */
module exec_top
    import regfile_exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cke,
    input  logic                  instr_valid,
    input  instr_t                instr,
    output logic                  result_valid,
    output reg_addr_t             result_rd,
    output logic [DATA_WIDTH-1:0] result_data
);

    localparam int READ_PORTS = 2;

    logic [READ_PORTS-1:0]                 rd_en;
    reg_addr_t [READ_PORTS-1:0]            rd_addr;
    logic [READ_PORTS-1:0][DATA_WIDTH-1:0] rd_dout;

    logic                  wb_en;
    reg_addr_t             wb_addr;
    logic [DATA_WIDTH-1:0] wb_data;

    exec_if exec_bus ();

    instr_decoder #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .dec         (exec_bus.decoder_mp)
    );

    // a frozen pipeline must not repeat the pending write-back
    register_file #(
        .READ_PORTS (READ_PORTS),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_regfile (
        .clk     (clk),
        .cke     (cke),
        .wr_en   (cke & wb_en),
        .wr_addr (wb_addr),
        .wr_din  (wb_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_dout (rd_dout)
    );

    alu_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (cke),
        .dec     (exec_bus.alu_mp),
        .rd_dout (rd_dout),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_din  (wb_data)
    );

    // the result ports show the write-back register directly
    assign result_valid = wb_en;
    assign result_rd    = wb_addr;
    assign result_data  = wb_data;

endmodule

/* sim/exec_checker.sv */
/*
 * Concurrent assertions on the execute top-level timing
 *   reset clear, freeze while cke is low, two-edge result latency
 *   bound into every exec_top instance
 */
module exec_checker
    import regfile_exec_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cke,
    input  logic                  instr_valid,
    input  instr_t                instr,
    input  logic                  result_valid,
    input  reg_addr_t             result_rd,
    input  logic [DATA_WIDTH-1:0] result_data
);

    logic accepted;

    // number of failed assertions, read by the testbench summary
    int failures = 0;

    // codes 0 to 7 are the defined operations, the rest are bubbles
    assign accepted = cke && instr_valid && !instr[OP_HI];

    // nothing can be in flight right after reset
    a_reset_clear: assert property (@(posedge clk) $rose(arst_n) |-> !result_valid)
        else begin
            failures++;
            $error("result_valid set in the first cycle after reset");
        end

    a_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        !cke |=> $stable(result_valid) && $stable(result_rd) && $stable(result_data))
        else begin
            failures++;
            $error("result outputs changed across a cycle with cke low");
        end

    // the second enabled edge after acceptance loads the result register
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        accepted |=> cke[->1] ##1 result_valid)
        else begin
            failures++;
            $error("no result two enabled edges after an accepted instruction");
        end

endmodule

bind exec_top exec_checker #(
    .DATA_WIDTH (DATA_WIDTH)
) u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .cke          (cke),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data)
);

/* sim/exec_tb.sv */
/*
 * Testbench for the execute subsystem
 *   directed tests against a reference register model
 *   clock, reset, result monitor, watchdog and summary
 */
module exec_tb
    import regfile_exec_pkg::*;
();

    localparam int DATA_WIDTH  = 32;
    localparam int CLK_PERIOD  = 8;
    // directed tests issue about 60 instructions, the random test 200
    localparam int INSTR_COUNT = 60 + 200;
    // gaps, stalls and drains stay well below three cycles per instruction
    localparam int WATCHDOG_TIME = INSTR_COUNT * 3 * CLK_PERIOD + 200 * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  cke;
    logic                  instr_valid;
    instr_t                instr;
    logic                  result_valid;
    reg_addr_t             result_rd;
    logic [DATA_WIDTH-1:0] result_data;

    logic [DATA_WIDTH-1:0] model_regs [32];
    reg_addr_t             exp_rd [$];
    logic [DATA_WIDTH-1:0] exp_data [$];
    reg_addr_t             exp_r;
    logic [DATA_WIDTH-1:0] exp_d;
    logic [31:0]           rng_state = 32'ha40be3b7;
    int                    errors = 0;
    int                    checks = 0;
    int                    results_seen = 0;

    // output values seen at the previous falling edge
    logic                  prev_cke = 1'b1;
    logic                  held_valid;
    reg_addr_t             held_rd;
    logic [DATA_WIDTH-1:0] held_data;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .cke          (cke),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic instr_t make_instr(input logic [3:0] op, input reg_addr_t rd,
            input reg_addr_t rs1, input reg_addr_t rs2, input imm_t imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_result(input logic [3:0] op,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b, input imm_t imm);
        logic [DATA_WIDTH-1:0] sext;
        sext = {{(DATA_WIDTH - 13){imm[12]}}, imm};
        case (op)
            OP_ADD:  expected_result = a + b;
            OP_SUB:  expected_result = a - b;
            OP_AND:  expected_result = a & b;
            OP_OR:   expected_result = a | b;
            OP_XOR:  expected_result = a ^ b;
            OP_SLL:  expected_result = a << b[4:0];
            OP_ADDI: expected_result = a + sext;
            OP_LI:   expected_result = sext;
            default: expected_result = '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
            input logic [31:0] got_v);
        $display("FAIL %s expected %h got %h", name, exp_v, got_v);
        errors++;
    endtask

    // an accepted instruction updates the model in program order
    task automatic model_accept(input instr_t w);
        logic [3:0]            op;
        logic [DATA_WIDTH-1:0] value;
        op = w[OP_HI:OP_LO];
        if (!op[3]) begin
            value = expected_result(op, model_regs[w[RS1_HI:RS1_LO]],
                                    model_regs[w[RS2_HI:RS2_LO]], w[IMM_HI:IMM_LO]);
            model_regs[w[RD_HI:RD_LO]] = value;
            exp_rd.push_back(w[RD_HI:RD_LO]);
            exp_data.push_back(value);
        end
    endtask

    task automatic drive_slot(input logic en, input logic valid, input instr_t w);
        @(posedge clk);
        #1;
        cke         = en;
        instr_valid = valid;
        instr       = w;
        if (en && valid) begin
            model_accept(w);
        end
    endtask

    task automatic issue(input logic [3:0] op, input int rd, input int rs1, input int rs2,
            input int imm);
        drive_slot(1'b1, 1'b1, make_instr(op, rd, rs1, rs2, imm_t'(imm)));
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_rd.size() != 0 && waited < 16) begin
            drive_slot(1'b1, 1'b0, '0);
            @(negedge clk);
            #1;
            waited++;
        end
        checks++;
        assert (exp_rd.size() == 0)
            else begin
                $display("%0d expected results never appeared", exp_rd.size());
                errors++;
            end
    endtask

    // outputs are settled at the falling edge, cke here decides the next rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (!prev_cke) begin
                checks++;
                assert (result_valid === held_valid && result_rd === held_rd &&
                        result_data === held_data)
                    else begin
                        $display("result outputs changed while cke was low");
                        errors++;
                    end
            end
            if (cke && result_valid) begin
                checks++;
                results_seen++;
                assert (exp_rd.size() != 0)
                    else begin
                        $display("result for r%0d arrived with none expected", result_rd);
                        errors++;
                    end
                if (exp_rd.size() != 0) begin
                    exp_r = exp_rd.pop_front();
                    exp_d = exp_data.pop_front();
                    assert (result_rd === exp_r)
                        else report_mismatch("result_rd", exp_r, result_rd);
                    assert (result_data === exp_d)
                        else report_mismatch("result_data", exp_d, result_data);
                end
            end
        end
        prev_cke   = cke;
        held_valid = result_valid;
        held_rd    = result_rd;
        held_data  = result_data;
    end

    task automatic test_reset();
        checks++;
        assert (result_valid === 1'b0)
            else report_mismatch("result_valid", 0, result_valid);
        repeat (6) begin
            drive_slot(1'b1, 1'b0, '0);
            @(negedge clk);
            checks++;
            assert (result_valid === 1'b0)
                else report_mismatch("result_valid", 0, result_valid);
        end
    endtask

    task automatic test_independent();
        int i;
        // negative and positive loads into r1 to r8
        for (i = 1; i <= 8; i++) begin
            issue(OP_LI, i, 0, 0, i * 517 - 2100);
        end
        repeat (3) drive_slot(1'b1, 1'b0, '0);
        for (i = 0; i <= 6; i++) begin
            issue(i, 10 + i, 1 + i, 8 - i, i * 300 - 1000);
        end
        drain_results();
    endtask

    task automatic test_forward_chain();
        issue(OP_LI, 3, 0, 0, 'h0a5);
        issue(OP_ADDI, 3, 3, 0, -7);
        issue(OP_ADD, 4, 3, 3, 0);
        issue(OP_SUB, 5, 4, 1, 0);
        issue(OP_XOR, 5, 5, 1, 0);
        issue(OP_SLL, 6, 5, 2, 0);
        issue(OP_OR, 7, 6, 6, 0);
        // forwarding on the second operand
        issue(OP_ADD, 8, 1, 7, 0);
        issue(OP_AND, 9, 2, 8, 0);
        drain_results();
    endtask

    task automatic test_bypass();
        issue(OP_LI, 20, 0, 0, 'h123);
        issue(OP_LI, 25, 0, 0, 'h0ff);
        issue(OP_ADD, 21, 20, 20, 0);
        issue(OP_XOR, 26, 25, 1, 0);
        issue(OP_SUB, 22, 21, 20, 0);
        issue(OP_LI, 23, 0, 0, -300);
        drive_slot(1'b1, 1'b0, '0);
        issue(OP_ADDI, 24, 23, 0, 1);
        repeat (3) drive_slot(1'b1, 1'b0, '0);
        issue(OP_OR, 27, 20, 21, 0);
        issue(OP_ADD, 28, 23, 24, 0);
        issue(OP_AND, 29, 26, 22, 0);
        drain_results();
    endtask

    task automatic test_cke_stall();
        issue(OP_LI, 9, 0, 0, 'h3c);
        // a valid strobe while frozen must be ignored
        repeat (3) drive_slot(1'b0, 1'b1, make_instr(OP_LI, 9, 0, 0, 13'h1fff));
        issue(OP_ADDI, 9, 9, 0, 1);
        repeat (2) drive_slot(1'b0, 1'b0, '0);
        issue(OP_ADD, 10, 9, 9, 0);
        issue(OP_ADDI, 11, 9, 0, -5);
        repeat (4) drive_slot(1'b0, 1'b1, make_instr(OP_ADD, 11, 10, 10, 0));
        issue(OP_SUB, 12, 11, 10, 0);
        issue(OP_XOR, 13, 12, 9, 0);
        drive_slot(1'b0, 1'b0, '0);
        drive_slot(1'b1, 1'b0, '0);
        issue(OP_SLL, 14, 13, 9, 0);
        drain_results();
    endtask

    task automatic test_random();
        int          issued;
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0]  op;
        instr_t      w;
        issued = 0;
        while (issued < 200) begin
            r  = next_rand();
            r2 = next_rand();
            // about one code in eight is undefined
            op = (r[31:29] == 3'd0) ? {1'b1, r[18:16]} : {1'b0, r[18:16]};
            w  = make_instr(op, {1'b0, r[27:24]}, {1'b0, r[23:20]}, {1'b0, r[15:12]},
                            r2[31:19]);
            if (r2[18:16] == 3'd0) begin
                drive_slot(1'b0, r2[13], w);
            end else if (r2[15:14] == 2'd0) begin
                drive_slot(1'b1, 1'b0, w);
            end else begin
                drive_slot(1'b1, 1'b1, w);
                issued++;
            end
        end
        drain_results();
    endtask

    initial begin
        watchdog();
    end

    task automatic watchdog();
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units", WATCHDOG_TIME);
        $display("tests failed");
        $finish;
    endtask

    initial begin
        int k;
        arst_n      = 1'b0;
        cke         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_independent();
        test_forward_chain();
        test_bypass();
        test_cke_stall();
        test_random();
        $display("checks %0d, results %0d, errors %0d, assertion failures %0d", checks,
                 results_seen, errors, dut0.u_checker.failures);
        if (errors == 0 && dut0.u_checker.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* regfile_exec.f */
design/regfile_exec_pkg.sv
design/exec_if.sv
design/ram32x1d.sv
design/register_file.sv
design/instr_decoder.sv
design/alu_stage.sv
design/exec_top.sv
sim/exec_checker.sv
sim/exec_tb.sv
